// ==== bench/trace_monitor_asserts.sv ====
// --------------------
// Concurrent checks on the monitor status, bound into the top level
// --------------------
`timescale 1ns/1ps
`default_nettype none

module trace_monitor_asserts (
  input logic                clk_i,
  input logic                rst_ni,
  input trace_pkg::chk_vec_t err_flags,
  input logic                err_any,
  input trace_pkg::cnt_t     err_count
);

  // Summary bit follows the flags
  any_matches_flags: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    err_any == (|err_flags)
  ) else $error("err_any differs from the OR of err_flags");

  // Once set, a flag stays set until the next reset
  flags_sticky: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ($past(err_flags) & ~err_flags) == '0
  ) else $error("an error flag cleared without a reset");

  count_monotonic: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    err_count >= $past(err_count)
  ) else $error("err_count decreased");

endmodule

`default_nettype wire

// ==== bench/trace_monitor_tb.sv ====
// --------------------
// Testbench for the trace monitor with directed and LFSR driven traces
// Outputs are compared each cycle with a reference model of the rules
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "monitor_defs.svh"

module trace_monitor_tb;

  import trace_pkg::*;
  import csr_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int N_DIRECTED = 150;
  localparam int N_RANDOM   = 500;
  localparam int N_SAT      = 300;
  localparam int TIMEOUT_NS = (N_DIRECTED + N_RANDOM + N_SAT + 20) * CLK_PERIOD;

  logic        clk_i;
  logic        rst_ni;
  logic        rvfi_valid;
  reg_addr_t   rs1_addr, rs2_addr;
  xlen_t       rs1_rdata, rs2_rdata;
  dbg_cause_e  rvfi_dbg;
  xlen_t       dcsr_rdata, mcause_wdata, mcause_wmask;
  logic        trap_exception, trap_debug, rvfi_dbg_mode, intr_valid;
  exc_cause_t  exception_cause;
  logic [2:0]  debug_cause;
  intr_cause_t intr_cause;

  chk_vec_t    err_flags;
  logic        err_any;
  check_e      first_err;
  cnt_t        err_count;

  // Reference model state
  logic        m_armed, m_was_dbg;
  chk_vec_t    m_flags;
  check_e      m_first;
  cnt_t        m_count;

  logic [31:0] lfsr_state = 32'h8f4e;

  trace_monitor_top trace_monitor_top_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rvfi_valid     (rvfi_valid),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .rs1_rdata      (rs1_rdata),
    .rs2_rdata      (rs2_rdata),
    .rvfi_dbg       (rvfi_dbg),
    .dcsr_rdata     (dcsr_rdata),
    .mcause_wdata   (mcause_wdata),
    .mcause_wmask   (mcause_wmask),
    .trap_exception (trap_exception),
    .trap_debug     (trap_debug),
    .rvfi_dbg_mode  (rvfi_dbg_mode),
    .exception_cause(exception_cause),
    .debug_cause    (debug_cause),
    .intr_valid     (intr_valid),
    .intr_cause     (intr_cause),
    .err_flags      (err_flags),
    .err_any        (err_any),
    .first_err      (first_err),
    .err_count      (err_count)
  );

  bind trace_monitor_top trace_monitor_asserts trace_monitor_asserts_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .err_flags(err_flags),
    .err_any  (err_any),
    .err_count(err_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Right shifting Galois LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = {1'b0, s[31:1]};
    if (s[0]) begin
      lfsr_step = lfsr_step ^ 32'h8020_0003;
    end
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    rand_bits = r;
  endfunction

  function automatic chk_vec_t flag_of(input check_e c);
    flag_of    = '0;
    flag_of[c] = 1'b1;
  endfunction

  function automatic check_e lowest_check(input chk_vec_t v);
    logic found;
    int   i;
    found        = 1'b0;
    lowest_check = CHK_RS1_RESET;
    for (i = 0; i < NUM_CHECKS; i++) begin
      if (v[i] && !found) begin
        lowest_check = check_e'(i);
        found        = 1'b1;
      end
    end
  endfunction

  // The seven rules applied to the trace currently on the inputs
  function automatic chk_vec_t ref_viol(input logic armed, input logic was_dbg);
    exc_cause_t masked;
    masked = mcause_wdata[`MON_EXC_W-1:0] & mcause_wmask[`MON_EXC_W-1:0];
    ref_viol = '0;
    if (rvfi_valid) begin
      ref_viol[CHK_RS1_RESET] = armed && (rs1_addr != '0) && (rs1_rdata != '0);
      ref_viol[CHK_RS2_RESET] = armed && (rs2_addr != '0) && (rs2_rdata != '0);
      ref_viol[CHK_DBG_CAUSE] = (rvfi_dbg != DBG_NONE) && !was_dbg &&
                                (rvfi_dbg != dcsr_rdata[`MON_DCSR_CAUSE_LSB +: 3]);
      ref_viol[CHK_EXC_CAUSE] = trap_exception && !rvfi_dbg_mode && (exception_cause != masked);
      ref_viol[CHK_EXC_NOCAUSE]  = trap_exception && (exception_cause == '0);
      ref_viol[CHK_INTR_NOCAUSE] = intr_valid && (intr_cause == '0);
      ref_viol[CHK_DBG_NOCAUSE]  = trap_debug && (debug_cause == '0);
    end
  endfunction

  task automatic model_reset();
    m_armed   = 1'b1;
    m_was_dbg = 1'b0;
    m_flags   = '0;
    m_first   = CHK_RS1_RESET;
    m_count   = '0;
  endtask

  task automatic model_step();
    chk_vec_t v;
    v = ref_viol(m_armed, m_was_dbg);
    if ((v != '0) && (m_flags == '0)) begin
      m_first = lowest_check(v);
    end
    m_flags = m_flags | v;
    if ((v != '0) && (m_count != '1)) begin
      m_count = m_count + cnt_t'(1);
    end
    if (rvfi_valid) begin
      m_armed   = 1'b0;
      m_was_dbg = rvfi_dbg_mode;
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic expect_status(input chk_vec_t flags, input check_e first, input cnt_t count);
    check_value("err_flags (directed)", 32'(err_flags), 32'(flags));
    check_value("first_err (directed)", 32'(first_err), 32'(first));
    check_value("err_count (directed)", 32'(err_count), 32'(count));
  endtask

  // Model steps on the edge that samples the trace and compares at the falling edge
  initial begin
    forever begin
      @(posedge clk_i);
      if (rst_ni) begin
        model_step();
      end
      @(negedge clk_i);
      if (!rst_ni) begin
        model_reset();
      end
      check_value("err_flags", 32'(err_flags), 32'(m_flags));
      check_value("err_any", 32'(err_any), 32'(|m_flags));
      check_value("first_err", 32'(first_err), 32'(m_first));
      check_value("err_count", 32'(err_count), 32'(m_count));
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Test FAILED");
    $fatal(1, "Watchdog expired");
  end

  task automatic clear_trace();
    rvfi_valid      <= 1'b0;
    rs1_addr        <= '0;
    rs2_addr        <= '0;
    rs1_rdata       <= '0;
    rs2_rdata       <= '0;
    rvfi_dbg        <= DBG_NONE;
    dcsr_rdata      <= '0;
    mcause_wdata    <= '0;
    mcause_wmask    <= '0;
    trap_exception  <= 1'b0;
    trap_debug      <= 1'b0;
    rvfi_dbg_mode   <= 1'b0;
    exception_cause <= '0;
    debug_cause     <= '0;
    intr_valid      <= 1'b0;
    intr_cause      <= '0;
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    clear_trace();
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  // Opens a retirement whose fields the caller fills in
  task automatic start_retire();
    @(posedge clk_i);
    clear_trace();
    rvfi_valid <= 1'b1;
  endtask

  // Lets the DUT sample the retirement and waits for stable outputs
  task automatic settle();
    @(posedge clk_i);
    clear_trace();
    @(negedge clk_i);
  endtask

  task automatic test_rs_reset();
    apply_reset();
    // x0 with data and a named register reading zero are both fine
    start_retire();
    rs1_rdata <= 32'hdead_beef;
    rs2_addr  <= 5'd7;
    settle();
    expect_status('0, CHK_RS1_RESET, '0);
    apply_reset();
    start_retire();
    rs1_addr  <= 5'd3;
    rs1_rdata <= 32'h0000_1234;
    settle();
    expect_status(flag_of(CHK_RS1_RESET), CHK_RS1_RESET, cnt_t'(1));
    start_retire();
    rs1_addr  <= 5'd3;
    rs1_rdata <= 32'h0000_1234;
    settle();
    expect_status(flag_of(CHK_RS1_RESET), CHK_RS1_RESET, cnt_t'(1));
    apply_reset();
    start_retire();
    rs2_addr  <= 5'd9;
    rs2_rdata <= 32'h8000_0000;
    settle();
    expect_status(flag_of(CHK_RS2_RESET), CHK_RS2_RESET, cnt_t'(1));
  endtask

  task automatic test_dbg_cause();
    int c;
    apply_reset();
    for (c = 1; c <= 4; c++) begin
      start_retire();
      rvfi_dbg   <= dbg_cause_e'(c);
      dcsr_rdata <= xlen_t'(c) << `MON_DCSR_CAUSE_LSB;
      settle();
    end
    expect_status('0, CHK_RS1_RESET, '0);
    start_retire();
    rvfi_dbg   <= DBG_STEP;
    dcsr_rdata <= xlen_t'(1) << `MON_DCSR_CAUSE_LSB;
    settle();
    expect_status(flag_of(CHK_DBG_CAUSE), CHK_DBG_CAUSE, cnt_t'(1));
    // No fresh cause is reported once already in debug mode
    apply_reset();
    start_retire();
    rvfi_dbg_mode <= 1'b1;
    settle();
    start_retire();
    rvfi_dbg_mode <= 1'b1;
    rvfi_dbg      <= DBG_STEP;
    dcsr_rdata    <= xlen_t'(1) << `MON_DCSR_CAUSE_LSB;
    settle();
    expect_status('0, CHK_RS1_RESET, '0);
  endtask

  task automatic test_exc_cause();
    apply_reset();
    start_retire();
    trap_exception  <= 1'b1;
    mcause_wdata    <= 32'h8000_000f;
    mcause_wmask    <= 32'h0000_0007;
    exception_cause <= 11'd7;
    settle();
    expect_status('0, CHK_RS1_RESET, '0);
    start_retire();
    trap_exception  <= 1'b1;
    mcause_wdata    <= 32'h0000_000d;
    mcause_wmask    <= '1;
    exception_cause <= 11'd5;
    settle();
    expect_status(flag_of(CHK_EXC_CAUSE), CHK_EXC_CAUSE, cnt_t'(1));
    apply_reset();
    start_retire();
    trap_exception  <= 1'b1;
    rvfi_dbg_mode   <= 1'b1;
    mcause_wdata    <= 32'h0000_000d;
    mcause_wmask    <= '1;
    exception_cause <= 11'd5;
    settle();
    expect_status('0, CHK_RS1_RESET, '0);
  endtask

  task automatic test_nocause();
    apply_reset();
    // Events without a valid retirement are ignored
    @(posedge clk_i);
    clear_trace();
    trap_exception <= 1'b1;
    intr_valid     <= 1'b1;
    trap_debug     <= 1'b1;
    settle();
    expect_status('0, CHK_RS1_RESET, '0);
    start_retire();
    trap_exception <= 1'b1;
    settle();
    expect_status(flag_of(CHK_EXC_NOCAUSE), CHK_EXC_NOCAUSE, cnt_t'(1));
    start_retire();
    intr_valid <= 1'b1;
    settle();
    expect_status(flag_of(CHK_EXC_NOCAUSE) | flag_of(CHK_INTR_NOCAUSE), CHK_EXC_NOCAUSE,
                  cnt_t'(2));
    start_retire();
    trap_debug <= 1'b1;
    settle();
    expect_status(7'b111_0000, CHK_EXC_NOCAUSE, cnt_t'(3));
  endtask

  task automatic drive_random();
    logic [31:0] r;
    logic [31:0] dcsr;
    logic [31:0] wdata;
    logic [31:0] wmask;
    logic [2:0]  dbg;
    @(posedge clk_i);
    r = rand_bits(2);
    rvfi_valid <= (r[1:0] != 2'b00);
    r = rand_bits(10);
    rs1_addr <= r[4:0];
    rs2_addr <= r[9:5];
    r = rand_bits(2);
    rs1_rdata <= r[0] ? rand_bits(32) : '0;
    rs2_rdata <= r[1] ? rand_bits(32) : '0;
    r = rand_bits(3);
    dbg = (r[2:0] > 3'd4) ? 3'd0 : r[2:0];
    rvfi_dbg <= dbg_cause_e'(dbg);
    dcsr = rand_bits(32);
    r = rand_bits(1);
    if (r[0]) begin
      dcsr[`MON_DCSR_CAUSE_LSB +: 3] = dbg;
    end
    dcsr_rdata <= dcsr;
    wdata = rand_bits(32);
    r = rand_bits(1);
    wmask = r[0] ? '1 : rand_bits(32);
    mcause_wdata <= wdata;
    mcause_wmask <= wmask;
    r = rand_bits(8);
    rvfi_dbg_mode  <= (r[1:0] == 2'b11);
    trap_exception <= (r[3:2] == 2'b11);
    trap_debug     <= (r[5:4] == 2'b11);
    intr_valid     <= (r[7:6] == 2'b11);
    r = rand_bits(2);
    if (r[1:0] != 2'b00) begin
      exception_cause <= wdata[`MON_EXC_W-1:0] & wmask[`MON_EXC_W-1:0];
    end else begin
      r = rand_bits(`MON_EXC_W);
      exception_cause <= r[`MON_EXC_W-1:0];
    end
    r = rand_bits(3 + `MON_INTR_W);
    debug_cause <= r[2:0];
    intr_cause  <= r[3 +: `MON_INTR_W];
  endtask

  initial begin
    rst_ni <= 1'b0;
    clear_trace();
    test_rs_reset();
    test_dbg_cause();
    test_exc_cause();
    test_nocause();
    apply_reset();
    repeat (N_RANDOM) drive_random();
    settle();
    // Enough violating cycles to pin the counter at all ones
    apply_reset();
    repeat (N_SAT) begin
      start_retire();
      intr_valid <= 1'b1;
    end
    settle();
    expect_status(flag_of(CHK_INTR_NOCAUSE), CHK_INTR_NOCAUSE, '1);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/cause_check.sv ====
// --------------------
// Trap, interrupt and debug cause checks on each retirement
// Tracks debug mode of the previous retirement
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "monitor_defs.svh"

module cause_check (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rvfi_valid,

  // Debug entry
  input  csr_pkg::dbg_cause_e  rvfi_dbg,
  input  trace_pkg::xlen_t     dcsr_rdata,
  input  logic                 rvfi_dbg_mode,

  // mcause write of the retirement
  input  trace_pkg::xlen_t     mcause_wdata,
  input  trace_pkg::xlen_t     mcause_wmask,

  // Trap record
  input  logic                 trap_exception,
  input  logic                 trap_debug,
  input  csr_pkg::exc_cause_t  exception_cause,
  input  logic [2:0]           debug_cause,

  // Interrupt record
  input  logic                 intr_valid,
  input  csr_pkg::intr_cause_t intr_cause,

  output trace_pkg::chk_vec_t  viol
);

  import trace_pkg::*;
  import csr_pkg::*;

  logic        was_dbg_mode;
  dcsr_cause_t dcsr_cause;
  exc_cause_t  mcause_exccode;

  logic dbg_cause_bad;
  logic exc_cause_bad;
  logic exc_nocause;
  logic intr_nocause;
  logic dbg_nocause;

  // Debug mode as seen by the last retirement
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      was_dbg_mode <= 1'b0;
    end else if (rvfi_valid) begin
      was_dbg_mode <= rvfi_dbg_mode;
    end
  end

  // dcsr.cause field
  assign dcsr_cause = dcsr_rdata[`MON_DCSR_CAUSE_LSB +: 3];

  // Exception code bits of the masked mcause write
  assign mcause_exccode = mcause_wdata[`MON_EXC_W-1:0] & mcause_wmask[`MON_EXC_W-1:0];

  // Only the entry into debug mode reports a fresh cause
  assign dbg_cause_bad = rvfi_valid && (rvfi_dbg != DBG_NONE) && !was_dbg_mode &&
                         (rvfi_dbg != dcsr_cause);

  // mcause is not written for exceptions taken in debug mode
  assign exc_cause_bad = rvfi_valid && trap_exception && !rvfi_dbg_mode &&
                         (exception_cause != mcause_exccode);

  // Every event must name a cause
  assign exc_nocause  = rvfi_valid && trap_exception && (exception_cause == '0);
  assign intr_nocause = rvfi_valid && intr_valid && (intr_cause == '0);
  assign dbg_nocause  = rvfi_valid && trap_debug && (debug_cause == '0);

  always_comb begin
    viol                   = '0;
    viol[CHK_DBG_CAUSE]    = dbg_cause_bad;
    viol[CHK_EXC_CAUSE]    = exc_cause_bad;
    viol[CHK_EXC_NOCAUSE]  = exc_nocause;
    viol[CHK_INTR_NOCAUSE] = intr_nocause;
    viol[CHK_DBG_NOCAUSE]  = dbg_nocause;
  end

endmodule

`default_nettype wire

// ==== hw/csr_pkg.sv ====
// --------------------
// Debug cause encoding and CSR field types
// --------------------
`default_nettype none

package csr_pkg;

`include "monitor_defs.svh"

  // Debug entry cause, same encoding as dcsr.cause
  typedef enum logic [2:0] {
    DBG_NONE    = 3'd0,
    DBG_EBREAK  = 3'd1,
    DBG_TRIGGER = 3'd2,
    DBG_HALTREQ = 3'd3,
    DBG_STEP    = 3'd4
  } dbg_cause_e;

  // Raw cause field extracted from dcsr
  typedef logic [2:0] dcsr_cause_t;

  // Exception code part of mcause
  typedef logic [`MON_EXC_W-1:0] exc_cause_t;

  // Interrupt cause part of mcause
  typedef logic [`MON_INTR_W-1:0] intr_cause_t;

endpackage

`default_nettype wire

// ==== hw/error_log.sv ====
// --------------------
// Collects violation pulses into sticky status
// First error code and saturating count of bad cycles
// --------------------
`timescale 1ns/1ps
`default_nettype none

module error_log (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  trace_pkg::chk_vec_t viol,
  output trace_pkg::chk_vec_t err_flags,
  output logic                err_any,
  output trace_pkg::check_e   first_err,
  output trace_pkg::cnt_t     err_count
);

  import trace_pkg::*;

  logic   viol_any;
  check_e viol_first;

  assign viol_any = |viol;

  // Lowest numbered violation wins, so scan from the top down
  always_comb begin
    viol_first = CHK_RS1_RESET;
    for (int i = NUM_CHECKS - 1; i >= 0; i--) begin
      if (viol[i]) begin
        viol_first = check_e'(i);
      end
    end
  end

  // Sticky flags
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_flags <= '0;
    end else begin
      err_flags <= err_flags | viol;
    end
  end

  assign err_any = |err_flags;

  // Capture only in the first cycle that has a violation
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_err <= CHK_RS1_RESET;
    end else if (viol_any && !err_any) begin
      first_err <= viol_first;
    end
  end

  // One count per bad cycle, holds at all ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_count <= '0;
    end else if (viol_any && (err_count != '1)) begin
      err_count <= err_count + cnt_t'(1);
    end
  end

endmodule

`default_nettype wire

// ==== hw/monitor_defs.svh ====
// --------------------
// Width and field position macros for the trace monitor
// Included by the packages and by modules that slice CSR data
// --------------------
`ifndef MONITOR_DEFS_SVH
`define MONITOR_DEFS_SVH

// Register and CSR data width of the core
`define MON_XLEN 32

// Exception code width as reported on the trap record
`define MON_EXC_W 11

// Interrupt cause width as reported on the interrupt record
`define MON_INTR_W 11

// First bit of the cause field in dcsr (dcsr.cause is bits 8:6)
`define MON_DCSR_CAUSE_LSB 6

// Error counter width, saturates at all ones
`define MON_CNT_W 8

`endif

// ==== hw/rs_reset_check.sv ====
// --------------------
// Checks that the first retirement after reset reads zero operands
// --------------------
`timescale 1ns/1ps
`default_nettype none

module rs_reset_check (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rvfi_valid,
  input  trace_pkg::reg_addr_t rs1_addr,
  input  trace_pkg::reg_addr_t rs2_addr,
  input  trace_pkg::xlen_t     rs1_rdata,
  input  trace_pkg::xlen_t     rs2_rdata,
  output trace_pkg::chk_vec_t  viol
);

  import trace_pkg::*;

  logic armed;
  logic rs1_bad;
  logic rs2_bad;

  // Armed from reset until the first retirement has been seen
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed <= 1'b1;
    end else if (rvfi_valid) begin
      armed <= 1'b0;
    end
  end

  // x0 always reads zero, so only a named register can be wrong
  assign rs1_bad = armed && rvfi_valid && (rs1_addr != '0) && (rs1_rdata != '0);
  assign rs2_bad = armed && rvfi_valid && (rs2_addr != '0) && (rs2_rdata != '0);

  // Only the two reset checks belong to this block
  always_comb begin
    viol                = '0;
    viol[CHK_RS1_RESET] = rs1_bad;
    viol[CHK_RS2_RESET] = rs2_bad;
  end

endmodule

`default_nettype wire

// ==== hw/trace_monitor_top.sv ====
// --------------------
// Top of the retirement trace monitor
// Connect to the RVFI port of the core and read the status outputs
// --------------------
`timescale 1ns/1ps
`default_nettype none

module trace_monitor_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Retirement trace
  input  logic                 rvfi_valid,
  input  trace_pkg::reg_addr_t rs1_addr,
  input  trace_pkg::reg_addr_t rs2_addr,
  input  trace_pkg::xlen_t     rs1_rdata,
  input  trace_pkg::xlen_t     rs2_rdata,
  input  csr_pkg::dbg_cause_e  rvfi_dbg,
  input  trace_pkg::xlen_t     dcsr_rdata,
  input  trace_pkg::xlen_t     mcause_wdata,
  input  trace_pkg::xlen_t     mcause_wmask,
  input  logic                 trap_exception,
  input  logic                 trap_debug,
  input  logic                 rvfi_dbg_mode,
  input  csr_pkg::exc_cause_t  exception_cause,
  input  logic [2:0]           debug_cause,
  input  logic                 intr_valid,
  input  csr_pkg::intr_cause_t intr_cause,

  // Status
  output trace_pkg::chk_vec_t  err_flags,
  output logic                 err_any,
  output trace_pkg::check_e    first_err,
  output trace_pkg::cnt_t      err_count
);

  trace_pkg::chk_vec_t viol_rs;
  trace_pkg::chk_vec_t viol_cause;
  trace_pkg::chk_vec_t viol_all;

  rs_reset_check rs_reset_check_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rvfi_valid(rvfi_valid),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rs1_rdata (rs1_rdata),
    .rs2_rdata (rs2_rdata),
    .viol      (viol_rs)
  );

  cause_check cause_check_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rvfi_valid     (rvfi_valid),
    .rvfi_dbg       (rvfi_dbg),
    .dcsr_rdata     (dcsr_rdata),
    .rvfi_dbg_mode  (rvfi_dbg_mode),
    .mcause_wdata   (mcause_wdata),
    .mcause_wmask   (mcause_wmask),
    .trap_exception (trap_exception),
    .trap_debug     (trap_debug),
    .exception_cause(exception_cause),
    .debug_cause    (debug_cause),
    .intr_valid     (intr_valid),
    .intr_cause     (intr_cause),
    .viol           (viol_cause)
  );

  // The two checkers own disjoint bits
  assign viol_all = viol_rs | viol_cause;

  error_log error_log_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .viol     (viol_all),
    .err_flags(err_flags),
    .err_any  (err_any),
    .first_err(first_err),
    .err_count(err_count)
  );

endmodule

`default_nettype wire

// ==== hw/trace_pkg.sv ====
// --------------------
// Types for the retirement trace and the check identifiers
// --------------------
`default_nettype none

package trace_pkg;

`include "monitor_defs.svh"

  // Operand data and register index of a retirement
  typedef logic [`MON_XLEN-1:0] xlen_t;
  typedef logic [4:0]           reg_addr_t;

  // Saturating violation counter
  typedef logic [`MON_CNT_W-1:0] cnt_t;

  // One identifier per rule, lowest value has the highest priority
  typedef enum logic [2:0] {
    CHK_RS1_RESET    = 3'd0,
    CHK_RS2_RESET    = 3'd1,
    CHK_DBG_CAUSE    = 3'd2,
    CHK_EXC_CAUSE    = 3'd3,
    CHK_EXC_NOCAUSE  = 3'd4,
    CHK_INTR_NOCAUSE = 3'd5,
    CHK_DBG_NOCAUSE  = 3'd6
  } check_e;

  localparam int unsigned NUM_CHECKS = 7;

  // Violation vector, bit n belongs to check n
  typedef logic [NUM_CHECKS-1:0] chk_vec_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the trace monitor testbench with Verilator
set -e

cd "$(dirname "$0")"
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module trace_monitor_tb \
  -f verilog.f \
  -o Vtrace_monitor_tb

status=0
./obj_dir/Vtrace_monitor_tb > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
echo "Simulation finished without failures"

// ==== verilog.f ====
+incdir+hw
hw/trace_pkg.sv
hw/csr_pkg.sv
hw/rs_reset_check.sv
hw/cause_check.sv
hw/error_log.sv
hw/trace_monitor_top.sv
bench/trace_monitor_asserts.sv
bench/trace_monitor_tb.sv
